// ==== all.f ====
cosine_cfg_pkg.sv
cosine_types_pkg.sv
row_sequencer.sv
stream_fifo.sv
row_accumulator.sv
cosine_similarity_top.sv
tb_cosine_similarity.sv

// ==== cosine_cfg_pkg.sv ====
////////////////////
// Sizing constants for the row-similarity engine.
// Referenced by scoped name from every other design file.
////////////////////

`default_nettype none

package cosine_cfg_pkg;

  ////////////////////
  // Datapath
  ////////////////////

  // Width of elements, modulus and accumulated terms
  localparam int DATA_W = 16;
  // Width of row and column indices and of the job sizes
  localparam int IDX_W = 8;

  // Bit counter of the shift-add multiplier
  localparam int BIT_W = $clog2(DATA_W);
  // First bit index, MSB-first
  localparam logic [BIT_W-1:0] BIT_TOP = BIT_W'(DATA_W - 1);

  ////////////////////
  // Buffering
  ////////////////////

  // Depths must be powers of two
  localparam int ELEM_DEPTH = 8;
  localparam int RES_DEPTH = 4;

endpackage

`default_nettype wire

// ==== cosine_similarity_top.sv ====
////////////////////
// Top level of the row-similarity engine. Sequencer feeds the element
// FIFO, the accumulator drains it and fills the result FIFO.
////////////////////

`timescale 1ns/10ps
`default_nettype none

module cosine_similarity_top (
  input  wire                               CLK,
  input  wire                               RST,
  input  wire                               START,
  input  wire [cosine_cfg_pkg::DATA_W-1:0]  MODULO,
  input  wire [cosine_cfg_pkg::IDX_W-1:0]   SIZE_I,
  input  wire [cosine_cfg_pkg::IDX_W-1:0]   SIZE_J,
  input  wire                               ELEM_STROBE,
  input  wire [cosine_cfg_pkg::DATA_W-1:0]  ELEM_A,
  input  wire [cosine_cfg_pkg::DATA_W-1:0]  ELEM_B,
  input  wire                               RESULT_POP,
  output logic                              BUSY,
  output logic                              ELEM_FULL,
  output logic                              RESULT_EMPTY,
  output cosine_types_pkg::row_result_t     RESULT
);

  cosine_types_pkg::job_cfg_t      cfg_in;
  cosine_types_pkg::elem_t         seq_elem;
  cosine_types_pkg::elem_t         head_elem;
  cosine_types_pkg::row_result_t   acc_result;
  logic [cosine_cfg_pkg::DATA_W-1:0] job_modulo;
  logic seq_push;
  logic elem_empty;
  logic elem_pop;
  logic res_full;
  logic res_push;
  logic job_done;

  // Config inputs packed for the sequencer
  assign cfg_in.modulo = MODULO;
  assign cfg_in.size_i = SIZE_I;
  assign cfg_in.size_j = SIZE_J;

  row_sequencer u_seq (
    .CLK(CLK), .RST(RST),
    .start(START), .cfg_in(cfg_in),
    .elem_strobe(ELEM_STROBE), .elem_a(ELEM_A), .elem_b(ELEM_B),
    .fifo_full(ELEM_FULL), .job_done(job_done),
    .busy(BUSY), .modulo(job_modulo),
    .push(seq_push), .elem(seq_elem)
  );

  // Element buffer
  stream_fifo #(.T(cosine_types_pkg::elem_t), .DEPTH(cosine_cfg_pkg::ELEM_DEPTH)) u_elem_fifo (
    .CLK(CLK), .RST(RST),
    .push(seq_push), .din(seq_elem),
    .pop(elem_pop), .dout(head_elem),
    .empty(elem_empty), .full(ELEM_FULL)
  );

  row_accumulator u_acc (
    .CLK(CLK), .RST(RST),
    .modulo(job_modulo),
    .elem(head_elem), .elem_empty(elem_empty), .elem_pop(elem_pop),
    .res_full(res_full), .res_push(res_push),
    .result(acc_result), .job_done(job_done)
  );

  // Result buffer
  stream_fifo #(.T(cosine_types_pkg::row_result_t), .DEPTH(cosine_cfg_pkg::RES_DEPTH)) u_res_fifo (
    .CLK(CLK), .RST(RST),
    .push(res_push), .din(acc_result),
    .pop(RESULT_POP), .dout(RESULT),
    .empty(RESULT_EMPTY), .full(res_full)
  );

endmodule

`default_nettype wire

// ==== cosine_types_pkg.sv ====
////////////////////
// Packed payload types shared by the sequencer, FIFOs and accumulator.
// Fields are sized from the sizing package.
////////////////////

`default_nettype none

package cosine_types_pkg;

  // Job description, latched on START
  typedef struct packed {
    logic [cosine_cfg_pkg::DATA_W-1:0] modulo;
    logic [cosine_cfg_pkg::IDX_W-1:0]  size_i;
    logic [cosine_cfg_pkg::IDX_W-1:0]  size_j;
  } job_cfg_t;

  // One element pair with its position tags
  typedef struct packed {
    logic [cosine_cfg_pkg::DATA_W-1:0] a;
    logic [cosine_cfg_pkg::DATA_W-1:0] b;
    logic [cosine_cfg_pkg::IDX_W-1:0]  row;
    // Last column of its row
    logic                              row_last;
    // Last element of the whole job
    logic                              job_last;
  } elem_t;

  // Per-row terms, all reduced by the job modulus
  typedef struct packed {
    logic [cosine_cfg_pkg::IDX_W-1:0]  row;
    logic [cosine_cfg_pkg::DATA_W-1:0] dot;
    logic [cosine_cfg_pkg::DATA_W-1:0] norm_a;
    logic [cosine_cfg_pkg::DATA_W-1:0] norm_b;
    // Final row of the job
    logic                              job_last;
  } row_result_t;

endpackage

`default_nettype wire

// ==== row_accumulator.sv ====
////////////////////
// Drains elements, forms a*b, a*a and b*b by modular shift-add and
// sums them per row. A finished row waits in EMIT until the result
// FIFO has room, which stalls the element FIFO behind it.
////////////////////

`timescale 1ns/10ps
`default_nettype none

module row_accumulator (
  input  wire                                CLK,
  input  wire                                RST,
  input  wire [cosine_cfg_pkg::DATA_W-1:0]   modulo,
  input  cosine_types_pkg::elem_t            elem,
  input  wire                                elem_empty,
  output logic                               elem_pop,
  input  wire                                res_full,
  output logic                               res_push,
  output cosine_types_pkg::row_result_t      result,
  output logic                               job_done
);

  typedef logic [cosine_cfg_pkg::DATA_W-1:0] word_t;
  typedef enum logic [1:0] {S_IDLE, S_MUL, S_EMIT} state_t;

  // (x + y) mod m, both operands already below m
  function automatic word_t mod_add(word_t x, word_t y, word_t m);
    logic [cosine_cfg_pkg::DATA_W:0] sum;
    sum = {1'b0, x} + {1'b0, y};
    if (sum >= {1'b0, m}) begin
      sum = sum - {1'b0, m};
    end
    return sum[cosine_cfg_pkg::DATA_W-1:0];
  endfunction

  // One MSB-first step: 2p, plus x when the multiplier bit is set
  function automatic word_t mod_step(word_t p, logic sel, word_t x, word_t m);
    word_t dbl;
    dbl = mod_add(p, p, m);
    return mod_add(dbl, sel ? x : '0, m);
  endfunction

  state_t                           state;
  logic [cosine_cfg_pkg::BIT_W-1:0] bit_cnt;
  cosine_types_pkg::elem_t          elem_q;
  cosine_types_pkg::row_result_t    result_q;

  // Partial products and row sums
  word_t p_ab, p_aa, p_bb;
  word_t acc_dot, acc_na, acc_nb;

  word_t nxt_ab, nxt_aa, nxt_bb;
  word_t sum_dot, sum_na, sum_nb;
  logic  last_step;
  logic  row_done;

  assign nxt_ab = mod_step(p_ab, elem_q.a[bit_cnt], elem_q.b, modulo);
  assign nxt_aa = mod_step(p_aa, elem_q.a[bit_cnt], elem_q.a, modulo);
  assign nxt_bb = mod_step(p_bb, elem_q.b[bit_cnt], elem_q.b, modulo);

  // Row sums including the product finishing this cycle
  assign sum_dot = mod_add(acc_dot, nxt_ab, modulo);
  assign sum_na  = mod_add(acc_na, nxt_aa, modulo);
  assign sum_nb  = mod_add(acc_nb, nxt_bb, modulo);

  assign last_step = (state == S_MUL) && (bit_cnt == '0);
  assign row_done  = last_step && elem_q.row_last;

  assign elem_pop = (state == S_IDLE) && !elem_empty;
  // Finished row held until the result FIFO has room
  assign res_push = (state == S_EMIT) && !res_full;
  assign job_done = res_push && result_q.job_last;
  assign result   = result_q;

  ////////////////////
  // FSM
  ////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      state   <= S_IDLE;
      bit_cnt <= '0;
      acc_dot <= '0;
      acc_na  <= '0;
      acc_nb  <= '0;
    end else begin
      case (state)
        S_IDLE: begin
          if (elem_pop) begin
            bit_cnt <= cosine_cfg_pkg::BIT_TOP;
            state   <= S_MUL;
          end
        end
        S_MUL: begin
          bit_cnt <= bit_cnt - 1'b1;
          if (row_done) begin
            // Row terms move to the result register
            acc_dot <= '0;
            acc_na  <= '0;
            acc_nb  <= '0;
            state   <= S_EMIT;
          end else if (last_step) begin
            acc_dot <= sum_dot;
            acc_na  <= sum_na;
            acc_nb  <= sum_nb;
            state   <= S_IDLE;
          end
        end
        S_EMIT: begin
          if (res_push) begin
            state <= S_IDLE;
          end
        end
        default: state <= S_IDLE;
      endcase
    end
  end

  ////////////////////
  // Datapath
  ////////////////////

  always_ff @(posedge CLK) begin
    // Operands captured with the pop, products start at zero
    if (elem_pop) begin
      elem_q <= elem;
      p_ab   <= '0;
      p_aa   <= '0;
      p_bb   <= '0;
    end else if (state == S_MUL) begin
      p_ab <= nxt_ab;
      p_aa <= nxt_aa;
      p_bb <= nxt_bb;
    end
    if (row_done) begin
      result_q.row      <= elem_q.row;
      result_q.dot      <= sum_dot;
      result_q.norm_a   <= sum_na;
      result_q.norm_b   <= sum_nb;
      result_q.job_last <= elem_q.job_last;
    end
  end

endmodule

`default_nettype wire

// ==== row_sequencer.sv ====
////////////////////
// Job front end. Latches the config on START, tags each accepted
// element with row index and end flags, and holds busy until the
// accumulator reports the last row pushed.
////////////////////

`timescale 1ns/10ps
`default_nettype none

module row_sequencer (
  input  wire                                 CLK,
  input  wire                                 RST,
  input  wire                                 start,
  input  cosine_types_pkg::job_cfg_t          cfg_in,
  input  wire                                 elem_strobe,
  input  wire [cosine_cfg_pkg::DATA_W-1:0]    elem_a,
  input  wire [cosine_cfg_pkg::DATA_W-1:0]    elem_b,
  input  wire                                 fifo_full,
  input  wire                                 job_done,
  output logic                                busy,
  output logic [cosine_cfg_pkg::DATA_W-1:0]   modulo,
  output logic                                push,
  output cosine_types_pkg::elem_t             elem
);

  ////////////////////
  // State
  ////////////////////

  cosine_types_pkg::job_cfg_t       cfg_q;
  logic [cosine_cfg_pkg::IDX_W-1:0] row_cnt;
  logic [cosine_cfg_pkg::IDX_W-1:0] col_cnt;
  // Whole job already fed, further strobes dropped
  logic                             feed_done;

  logic start_ok;
  logic at_row_end;
  logic at_job_end;

  // New jobs only from idle
  assign start_ok = start && !busy;

  assign at_row_end = (col_cnt == cfg_q.size_j - 1'b1);
  assign at_job_end = at_row_end && (row_cnt == cfg_q.size_i - 1'b1);

  // Strobe goes straight into the FIFO on the sampling edge
  assign push = elem_strobe && busy && !fifo_full && !feed_done;

  assign elem.a        = elem_a;
  assign elem.b        = elem_b;
  assign elem.row      = row_cnt;
  assign elem.row_last = at_row_end;
  assign elem.job_last = at_job_end;

  // Stable for the whole job
  assign modulo = cfg_q.modulo;

  ////////////////////
  // Control
  ////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      busy      <= 1'b0;
      feed_done <= 1'b0;
      row_cnt   <= '0;
      col_cnt   <= '0;
    end else begin
      if (start_ok) begin
        busy      <= 1'b1;
        feed_done <= 1'b0;
        row_cnt   <= '0;
        col_cnt   <= '0;
      end else if (job_done) begin
        busy <= 1'b0;
      end
      // Column wraps at row end, row steps on
      if (push) begin
        if (at_row_end) begin
          col_cnt <= '0;
          row_cnt <= row_cnt + 1'b1;
        end else begin
          col_cnt <= col_cnt + 1'b1;
        end
        if (at_job_end) begin
          feed_done <= 1'b1;
        end
      end
    end
  end

  // Job description
  always_ff @(posedge CLK) begin
    if (start_ok) begin
      cfg_q <= cfg_in;
    end
  end

endmodule

`default_nettype wire

// ==== run.sh ====
#!/bin/sh
# Build the testbench with Verilator and run it
set -e
cd "$(dirname "$0")"

verilator --binary --timing -j 0 --top-module tb_cosine_similarity -f all.f

# The simulator exits non-zero on a fatal check, so keep its output either way
out=$(./obj_dir/Vtb_cosine_similarity 2>&1 || true)
printf '%s\n' "$out"

if printf '%s\n' "$out" | grep -q "Verification passed"; then
  exit 0
else
  exit 1
fi

// ==== stream_fifo.sv ====
////////////////////
// Show-ahead FIFO for any packed payload. Head is valid at dout
// whenever empty is low; pop consumes it on the clock edge.
////////////////////

`timescale 1ns/10ps
`default_nettype none

module stream_fifo #(
  parameter type T     = cosine_types_pkg::elem_t,
  parameter int  DEPTH = cosine_cfg_pkg::ELEM_DEPTH
) (
  input  wire  CLK,
  input  wire  RST,
  input  wire  push,
  input  T     din,
  input  wire  pop,
  output T     dout,
  output logic empty,
  output logic full
);

  // Storage, power-of-two depth so pointers wrap naturally
  T mem [DEPTH];

  logic [$clog2(DEPTH)-1:0]   wr_ptr;
  logic [$clog2(DEPTH)-1:0]   rd_ptr;
  logic [$clog2(DEPTH+1)-1:0] count;

  logic do_push;
  logic do_pop;

  // Overflow and underflow requests dropped
  assign do_push = push && !full;
  assign do_pop  = pop && !empty;

  assign empty = (count == '0);
  assign full  = (int'(count) == DEPTH);
  assign dout  = mem[rd_ptr];

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_push) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (do_pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      // Occupancy holds on simultaneous push and pop
      case ({do_push, do_pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  always_ff @(posedge CLK) begin
    if (do_push) begin
      mem[wr_ptr] <= din;
    end
  end

endmodule

`default_nettype wire

// ==== tb_cosine_similarity.sv ====
////////////////////
// Testbench for the row-similarity engine. Streams random jobs,
// compares every popped row against a software model of the sums.
////////////////////

`timescale 1ns/10ps
`default_nettype none

module tb_cosine_similarity;

  typedef logic [cosine_cfg_pkg::DATA_W-1:0] word_t;
  typedef logic [cosine_cfg_pkg::IDX_W-1:0]  idx_t;

  // Cycles any single wait may take
  localparam int WAIT_LIMIT = 4000;

  logic CLK;
  logic RST;
  logic START;
  word_t MODULO;
  idx_t SIZE_I;
  idx_t SIZE_J;
  logic ELEM_STROBE;
  word_t ELEM_A;
  word_t ELEM_B;
  logic RESULT_POP;
  logic BUSY;
  logic ELEM_FULL;
  logic RESULT_EMPTY;
  cosine_types_pkg::row_result_t RESULT;

  // Stimulus state shared with the model and the comparer
  logic [31:0] rng_state;
  word_t a_mem [256];
  word_t b_mem [256];
  cosine_types_pkg::row_result_t exp_q [$];
  logic pop_en;

  cosine_similarity_top u_dut (
    .CLK(CLK), .RST(RST), .START(START),
    .MODULO(MODULO), .SIZE_I(SIZE_I), .SIZE_J(SIZE_J),
    .ELEM_STROBE(ELEM_STROBE), .ELEM_A(ELEM_A), .ELEM_B(ELEM_B),
    .RESULT_POP(RESULT_POP), .BUSY(BUSY), .ELEM_FULL(ELEM_FULL),
    .RESULT_EMPTY(RESULT_EMPTY), .RESULT(RESULT)
  );

  initial begin
    CLK = 1'b0;
    forever #20 CLK = ~CLK;
  end

  ////////////////////
  // Helpers
  ////////////////////

  function automatic logic [31:0] next_random();
    rng_state = rng_state ^ (rng_state << 13);
    rng_state = rng_state ^ (rng_state >> 17);
    rng_state = rng_state ^ (rng_state << 5);
    return rng_state;
  endfunction

  // Model of one row: plain sums of products, reduced at each step
  function automatic cosine_types_pkg::row_result_t ref_row(int row, int sj, word_t m,
                                                            logic last);
    cosine_types_pkg::row_result_t r;
    logic [63:0] dot;
    logic [63:0] na;
    logic [63:0] nb;
    logic [63:0] a;
    logic [63:0] b;
    dot = '0;
    na  = '0;
    nb  = '0;
    for (int c = 0; c < sj; c++) begin
      a   = 64'(a_mem[row * sj + c]);
      b   = 64'(b_mem[row * sj + c]);
      dot = (dot + a * b) % 64'(m);
      na  = (na + a * a) % 64'(m);
      nb  = (nb + b * b) % 64'(m);
    end
    r.row      = idx_t'(row);
    r.dot      = word_t'(dot);
    r.norm_a   = word_t'(na);
    r.norm_b   = word_t'(nb);
    r.job_last = last;
    return r;
  endfunction

  task automatic report_fail(string why);
    $display("%s", why);
    $display("Verification failed");
    $fatal(1);
  endtask

  task automatic check_value(string name, logic [31:0] got, logic [31:0] exp);
    if (got !== exp) begin
      report_fail($sformatf("CHECK FAILED %s got 0x%0h expected 0x%0h", name, got, exp));
    end
  endtask

  ////////////////////
  // Job driver
  ////////////////////

  // Drives one job and queues its expected rows
  // Elements all m-1 with fill_max
  // Popping held for hold_cycles once a result is waiting
  // Stray START right after the real one with restart
  task automatic run_job(word_t m, int si, int sj, bit fill_max, int hold_cycles,
                         bit restart);
    int t;
    for (int k = 0; k < si * sj; k++) begin
      a_mem[k] = fill_max ? m - 1'b1 : word_t'(next_random() % 32'(m));
      b_mem[k] = fill_max ? m - 1'b1 : word_t'(next_random() % 32'(m));
    end
    for (int r = 0; r < si; r++) begin
      exp_q.push_back(ref_row(r, sj, m, r == si - 1));
    end
    pop_en = (hold_cycles == 0);
    START  = 1'b1;
    MODULO = m;
    SIZE_I = idx_t'(si);
    SIZE_J = idx_t'(sj);
    @(negedge CLK);
    START = 1'b0;
    check_value("BUSY", 32'(BUSY), 32'd1);
    // Must be dropped, job keeps its own modulo and sizes
    if (restart) begin
      START  = 1'b1;
      MODULO = 16'd7;
      SIZE_I = 8'd1;
      SIZE_J = 8'd1;
      @(negedge CLK);
      START = 1'b0;
    end
    for (int k = 0; k < si * sj; k++) begin
      t = 0;
      while (ELEM_FULL && t < WAIT_LIMIT) begin
        @(negedge CLK);
        t++;
      end
      if (ELEM_FULL) report_fail("element FIFO stayed full");
      ELEM_A      = a_mem[k];
      ELEM_B      = b_mem[k];
      ELEM_STROBE = 1'b1;
      @(negedge CLK);
      ELEM_STROBE = 1'b0;
    end
    if (hold_cycles > 0) begin
      t = 0;
      while (RESULT_EMPTY && t < WAIT_LIMIT) begin
        @(negedge CLK);
        t++;
      end
      if (RESULT_EMPTY) report_fail("no row result arrived while popping was held");
      // Results pile up while the job is still running
      repeat (hold_cycles) begin
        check_value("BUSY", 32'(BUSY), 32'd1);
        check_value("RESULT_EMPTY", 32'(RESULT_EMPTY), 32'd0);
        @(negedge CLK);
      end
      pop_en = 1'b1;
    end
    t = 0;
    while (BUSY && t < WAIT_LIMIT) begin
      @(negedge CLK);
      t++;
    end
    if (BUSY) report_fail("BUSY did not fall at the end of the job");
    t = 0;
    while (exp_q.size() != 0 && t < WAIT_LIMIT) begin
      @(negedge CLK);
      t++;
    end
    if (exp_q.size() != 0) report_fail("expected row results never arrived");
  endtask

  ////////////////////
  // Result comparer
  ////////////////////

  initial begin : compare_results
    cosine_types_pkg::row_result_t exp_r;
    forever begin
      @(negedge CLK);
      RESULT_POP = 1'b0;
      if (!RST && pop_en && !RESULT_EMPTY) begin
        if (exp_q.size() == 0) report_fail("row result appeared with none expected");
        exp_r = exp_q.pop_front();
        check_value("RESULT.row", 32'(RESULT.row), 32'(exp_r.row));
        check_value("RESULT.dot", 32'(RESULT.dot), 32'(exp_r.dot));
        check_value("RESULT.norm_a", 32'(RESULT.norm_a), 32'(exp_r.norm_a));
        check_value("RESULT.norm_b", 32'(RESULT.norm_b), 32'(exp_r.norm_b));
        check_value("RESULT.job_last", 32'(RESULT.job_last), 32'(exp_r.job_last));
        RESULT_POP = 1'b1;
      end
    end
  end

  ////////////////////
  // Main sequence
  ////////////////////

  initial begin : stimulus
    int si;
    int sj;
    rng_state   = 32'h78d7a1b5;
    RST         = 1'b1;
    START       = 1'b0;
    MODULO      = '0;
    SIZE_I      = '0;
    SIZE_J      = '0;
    ELEM_STROBE = 1'b0;
    ELEM_A      = '0;
    ELEM_B      = '0;
    RESULT_POP  = 1'b0;
    pop_en      = 1'b1;
    repeat (10) @(posedge CLK);
    @(negedge CLK);
    RST = 1'b0;
    check_value("BUSY", 32'(BUSY), 32'd0);
    check_value("ELEM_FULL", 32'(ELEM_FULL), 32'd0);
    check_value("RESULT_EMPTY", 32'(RESULT_EMPTY), 32'd1);
    // Single element of m-1, every term is 1
    run_job(16'd101, 1, 1, 1'b1, 0, 1'b0);
    run_job(16'd32749, 3, 5, 1'b0, 0, 1'b0);
    // Element FIFO back-pressure with popping held
    run_job(16'd1021, 4, 4, 1'b0, 10, 1'b0);
    // Six rows against a four-deep result FIFO stall the accumulator
    // Hold outlasts the whole job, so BUSY only stays up through the stall
    run_job(16'd2039, 6, 2, 1'b0, 6 * 2 * (cosine_cfg_pkg::DATA_W + 1), 1'b0);
    run_job(16'd4093, 2, 3, 1'b0, 0, 1'b1);
    // Back to back, different moduli and random sizes
    si = 1 + int'(next_random() % 32'd4);
    sj = 1 + int'(next_random() % 32'd6);
    run_job(16'd9973, si, sj, 1'b0, 0, 1'b0);
    si = 1 + int'(next_random() % 32'd4);
    sj = 1 + int'(next_random() % 32'd6);
    run_job(16'd257, si, sj, 1'b0, 0, 1'b0);
    $display("Verification passed");
    $finish;
  end

endmodule

`default_nettype wire
